// ==== files.f ====
+incdir+include
logic/periph_pkg.sv
logic/apb_slot_decode.sv
logic/apb_timer.sv
logic/irq_ctrl.sv
logic/periph_top.sv
testbench/tb_periph_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_periph_top -f files.f \
    && ./obj_dir/Vtb_periph_top | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== testbench/tb_periph_top.sv ====
`timescale 1ns/1ps

// ----------------------------------------
// Testbench for the peripheral subsystem
// APB driver tasks, directed tests of the
// slot decode, timer and interrupt control
// ----------------------------------------

`include "periph_defs.svh"

module tb_periph_top
    import periph_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // About 120 transfers of 3 cycles each plus polls, with wide margin
    localparam int MAX_CYCLES = 5000;

    logic      clk_i;
    logic      rst_n_i;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    apb_addr_t paddr_i;
    apb_data_t pwdata_i;
    apb_data_t prdata_o;
    logic      pready_o;
    logic      pslverr_o;
    logic      irq_o;
    integer    seed = 32'h637efc2d;
    int        cycles = 0;

    periph_top i_periph_top (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .irq_o     ( irq_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic compare_value(input string name, input apb_data_t expected,
                                 input apb_data_t actual);
        assert (actual === expected) else begin
            report_failure($sformatf("[FAIL] %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_failure("Timeout: the run went past the cycle limit");
        end
    end

    // ----------------------------------------
    // APB master
    // ----------------------------------------

    function automatic apb_addr_t reg_addr(input logic [3:0] slot, input int off);
        apb_addr_t addr;
        addr                              = '0;
        addr[`SLOT_MSB:`SLOT_LSB]         = slot;
        addr[`REG_OFF_MSB:`REG_OFF_LSB]   = reg_off_t'(off);
        return addr;
    endfunction

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        // Sample mid access cycle, away from both edges
        #(CLK_PERIOD / 4);
        assert (pready_o) else report_failure("pready_o was low in an access cycle");
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // Bounded poll of the pending register
    task automatic wait_pending(input apb_data_t mask);
        apb_data_t data;
        logic      err;
        int        polls;
        data  = '0;
        polls = 0;
        while ((data & mask) != mask && polls < 20) begin
            apb_read(reg_addr(`SLOT_IRQ, 0), data, err);
            polls++;
        end
        assert ((data & mask) == mask) else begin
            report_failure($sformatf("Pending bits %h never got set", mask));
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic reset_state();
        apb_data_t data;
        logic      err;
        compare_value("reset_state irq_o", '0, apb_data_t'(irq_o));
        for (int off = 0; off < 6; off++) begin
            apb_read(reg_addr(`SLOT_TIMER, off), data, err);
            compare_value("reset_state timer reg", '0, data);
            compare_value("reset_state timer pslverr", '0, apb_data_t'(err));
        end
        for (int off = 0; off < 3; off++) begin
            apb_read(reg_addr(`SLOT_IRQ, off), data, err);
            compare_value("reset_state irq reg", '0, data);
            compare_value("reset_state irq pslverr", '0, apb_data_t'(err));
        end
    endtask

    task automatic register_access();
        logic [3:0] empty_slots [3] = '{4'd2, 4'd3, 4'd9};
        apb_data_t  cmp0;
        apb_data_t  cmp1;
        apb_data_t  en_val;
        apb_data_t  data;
        logic       err;
        cmp0   = $random(seed);
        cmp1   = $random(seed);
        en_val = $random(seed);
        apb_write(reg_addr(`SLOT_TIMER, 1), cmp0, err);
        apb_write(reg_addr(`SLOT_TIMER, 4), cmp1, err);
        apb_write(reg_addr(`SLOT_IRQ, 1), en_val, err);
        for (int i = 0; i < 3; i++) begin
            apb_write(reg_addr(empty_slots[i], 1), ~cmp0, err);
            compare_value("register_access empty write pslverr", 32'd1, apb_data_t'(err));
            apb_read(reg_addr(empty_slots[i], 1), data, err);
            compare_value("register_access empty read data", 32'hdeadbeef, data);
            compare_value("register_access empty read pslverr", 32'd1, apb_data_t'(err));
        end
        apb_read(reg_addr(`SLOT_TIMER, 1), data, err);
        compare_value("register_access compare 0", cmp0, data);
        apb_read(reg_addr(`SLOT_TIMER, 4), data, err);
        compare_value("register_access compare 1", cmp1, data);
        // Only sources 1 and 2 can be enabled
        apb_read(reg_addr(`SLOT_IRQ, 1), data, err);
        compare_value("register_access enable", en_val & 32'h6, data);
    endtask

    task automatic timer_wrap();
        apb_data_t data;
        apb_data_t first;
        logic      err;
        apb_write(reg_addr(`SLOT_TIMER, 1), 32'd20, err);
        apb_write(reg_addr(`SLOT_TIMER, 2), 32'd0, err);
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd1, err);
        for (int i = 0; i < 12; i++) begin
            apb_read(reg_addr(`SLOT_TIMER, 2), data, err);
            assert (data <= 32'd20) else begin
                report_failure($sformatf("[FAIL] timer_wrap count: expected 0 to 20, actual %h",
                                         data));
            end
        end
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd0, err);
        apb_read(reg_addr(`SLOT_TIMER, 2), first, err);
        apb_read(reg_addr(`SLOT_TIMER, 2), data, err);
        compare_value("timer_wrap held count", first, data);
    endtask

    task automatic interrupt_flow();
        apb_data_t data;
        logic      err;
        apb_write(reg_addr(`SLOT_IRQ, 0), 32'h6, err);
        apb_write(reg_addr(`SLOT_IRQ, 1), 32'h2, err);
        apb_write(reg_addr(`SLOT_TIMER, 1), 32'd10, err);
        apb_write(reg_addr(`SLOT_TIMER, 2), 32'd0, err);
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd1, err);
        wait_pending(32'h2);
        compare_value("interrupt_flow irq_o high", 32'd1, apb_data_t'(irq_o));
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd0, err);
        apb_read(reg_addr(`SLOT_IRQ, 2), data, err);
        compare_value("interrupt_flow claim", 32'd1, data);
        apb_read(reg_addr(`SLOT_IRQ, 0), data, err);
        compare_value("interrupt_flow pending bit 1", '0, data & 32'h2);
        repeat (2) @(negedge clk_i);
        compare_value("interrupt_flow irq_o low", '0, apb_data_t'(irq_o));
    endtask

    task automatic masking_order();
        apb_data_t data;
        logic      err;
        apb_write(reg_addr(`SLOT_IRQ, 1), 32'h0, err);
        apb_write(reg_addr(`SLOT_IRQ, 0), 32'h6, err);
        apb_write(reg_addr(`SLOT_TIMER, 1), 32'd5, err);
        apb_write(reg_addr(`SLOT_TIMER, 2), 32'd0, err);
        apb_write(reg_addr(`SLOT_TIMER, 4), 32'd7, err);
        apb_write(reg_addr(`SLOT_TIMER, 5), 32'd0, err);
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd1, err);
        apb_write(reg_addr(`SLOT_TIMER, 3), 32'd1, err);
        wait_pending(32'h6);
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd0, err);
        apb_write(reg_addr(`SLOT_TIMER, 3), 32'd0, err);
        apb_read(reg_addr(`SLOT_IRQ, 0), data, err);
        compare_value("masking_order pending", 32'h6, data);
        compare_value("masking_order irq_o masked", '0, apb_data_t'(irq_o));
        apb_read(reg_addr(`SLOT_IRQ, 2), data, err);
        compare_value("masking_order masked claim", '0, data);
        // Lowest numbered source is claimed first
        apb_write(reg_addr(`SLOT_IRQ, 1), 32'h6, err);
        apb_read(reg_addr(`SLOT_IRQ, 2), data, err);
        compare_value("masking_order first claim", 32'd1, data);
        apb_read(reg_addr(`SLOT_IRQ, 2), data, err);
        compare_value("masking_order second claim", 32'd2, data);
        // Set pending bit 1 again before the clear
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd1, err);
        wait_pending(32'h2);
        apb_write(reg_addr(`SLOT_TIMER, 0), 32'd0, err);
        apb_write(reg_addr(`SLOT_IRQ, 0), 32'h6, err);
        apb_read(reg_addr(`SLOT_IRQ, 0), data, err);
        compare_value("masking_order pending cleared", '0, data);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        reset_state();
        register_access();
        timer_wrap();
        interrupt_flow();
        masking_order();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== logic/periph_top.sv ====
`timescale 1ns/1ps

// -------------------------------------
// Peripheral subsystem top with slot
// decode, timer and interrupt control
// -------------------------------------

module periph_top
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      irq_o
);

    logic       sel_irq;
    logic       sel_timer;
    reg_off_t   reg_off;
    apb_data_t  irq_rdata;
    apb_data_t  timer_rdata;
    logic [1:0] timer_evt;

    apb_slot_decode i_apb_slot_decode (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .paddr_i       ( paddr_i     ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .sel_irq_o     ( sel_irq     ),
        .sel_timer_o   ( sel_timer   ),
        .reg_off_o     ( reg_off     ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    apb_timer i_apb_timer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .sel_i       ( sel_timer   ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .reg_off_i   ( reg_off     ),
        .pwdata_i    ( pwdata_i    ),
        .rdata_o     ( timer_rdata ),
        .timer_evt_o ( timer_evt   )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .sel_i       ( sel_irq   ),
        .penable_i   ( penable_i ),
        .pwrite_i    ( pwrite_i  ),
        .reg_off_i   ( reg_off   ),
        .pwdata_i    ( pwdata_i  ),
        .timer_evt_i ( timer_evt ),
        .rdata_o     ( irq_rdata ),
        .irq_o       ( irq_o     )
    );

endmodule

// ==== logic/irq_ctrl.sv ====
`timescale 1ns/1ps

// -------------------------------------
// Interrupt controller with pending,
// enable and claim registers driving a
// single external interrupt line
// -------------------------------------

`include "periph_defs.svh"

module irq_ctrl
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       sel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  reg_off_t   reg_off_i,
    input  apb_data_t  pwdata_i,
    input  logic [1:0] timer_evt_i,
    output apb_data_t  rdata_o,
    output logic       irq_o
);

    localparam reg_off_t OFF_PENDING = reg_off_t'(0);
    localparam reg_off_t OFF_ENABLE  = reg_off_t'(1);
    localparam reg_off_t OFF_CLAIM   = reg_off_t'(2);

    // Source 0 is reserved and can never be enabled
    localparam irq_vec_t SRC_MASK = ~irq_vec_t'(1);

    logic     wr_en;
    logic     claim_rd;
    irq_vec_t src_evt;
    irq_vec_t pending_q;
    irq_vec_t pending_d;
    irq_vec_t enable_q;
    irq_vec_t active;
    irq_id_t  claim_id;
    logic     irq_q;

    assign wr_en    = sel_i & penable_i & pwrite_i;
    assign claim_rd = sel_i & penable_i & ~pwrite_i & (reg_off_i == OFF_CLAIM);

    always_comb begin
        src_evt                  = '0;
        src_evt[`IRQ_SRC_TIMER0] = timer_evt_i[0];
        src_evt[`IRQ_SRC_TIMER1] = timer_evt_i[1];
    end

    assign active = pending_q & enable_q;

    // Lowest numbered active source wins
    always_comb begin
        claim_id = '0;
        for (int src = `NUM_IRQ_SRC - 1; src > 0; src--) begin
            if (active[src]) begin
                claim_id = irq_id_t'(src);
            end
        end
    end

    // New events override a clear in the same cycle
    always_comb begin
        pending_d = pending_q;
        if (wr_en && reg_off_i == OFF_PENDING) begin
            pending_d = pending_d & ~irq_vec_t'(pwdata_i);
        end
        if (claim_rd && claim_id != '0) begin
            pending_d[claim_id] = 1'b0;
        end
        pending_d = pending_d | src_evt;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            pending_q <= pending_d;
            if (wr_en && reg_off_i == OFF_ENABLE) begin
                enable_q <= irq_vec_t'(pwdata_i) & SRC_MASK;
            end
            irq_q <= |active;
        end
    end

    assign irq_o = irq_q;

    always_comb begin
        case (reg_off_i)
            OFF_PENDING: rdata_o = apb_data_t'(pending_q);
            OFF_ENABLE:  rdata_o = apb_data_t'(enable_q);
            OFF_CLAIM:   rdata_o = apb_data_t'(claim_id);
            default:     rdata_o = '0;
        endcase
    end

endmodule

// ==== logic/apb_timer.sv ====
`timescale 1ns/1ps

// -------------------------------------
// Two channel compare timer with APB
// registers and one event pulse per
// channel on compare match
// -------------------------------------

module apb_timer
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       sel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  reg_off_t   reg_off_i,
    input  apb_data_t  pwdata_i,
    output apb_data_t  rdata_o,
    output logic [1:0] timer_evt_o
);

    localparam int NUM_CH      = 2;
    localparam int REGS_PER_CH = 3;

    // Register index inside a channel
    localparam int IDX_CTRL = 0;
    localparam int IDX_CMP  = 1;
    localparam int IDX_CNT  = 2;

    logic              wr_en;
    logic [NUM_CH-1:0] en_q;
    logic [NUM_CH-1:0] hit;
    apb_data_t         cmp_q [NUM_CH];
    apb_data_t         cnt_q [NUM_CH];

    function automatic reg_off_t ch_off(input int ch, input int idx);
        return reg_off_t'(REGS_PER_CH * ch + idx);
    endfunction

    assign wr_en = sel_i & penable_i & pwrite_i;

    // Match on compare ends the period
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            hit[ch] = en_q[ch] && (cnt_q[ch] == cmp_q[ch]);
        end
    end

    assign timer_evt_o = hit;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q  <= '0;
            cmp_q <= '{default: '0};
            cnt_q <= '{default: '0};
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (wr_en && reg_off_i == ch_off(ch, IDX_CTRL)) begin
                    en_q[ch] <= pwdata_i[0];
                end
                if (wr_en && reg_off_i == ch_off(ch, IDX_CMP)) begin
                    cmp_q[ch] <= pwdata_i;
                end
                // A bus write to the count wins over counting
                if (wr_en && reg_off_i == ch_off(ch, IDX_CNT)) begin
                    cnt_q[ch] <= pwdata_i;
                end else if (hit[ch]) begin
                    cnt_q[ch] <= '0;
                end else if (en_q[ch]) begin
                    cnt_q[ch] <= cnt_q[ch] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------
    // Read mux
    // ----------------------------------

    // Offsets past the last channel read zero
    always_comb begin
        rdata_o = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (reg_off_i == ch_off(ch, IDX_CTRL)) begin
                rdata_o = apb_data_t'(en_q[ch]);
            end
            if (reg_off_i == ch_off(ch, IDX_CMP)) begin
                rdata_o = cmp_q[ch];
            end
            if (reg_off_i == ch_off(ch, IDX_CNT)) begin
                rdata_o = cnt_q[ch];
            end
        end
    end

endmodule

// ==== logic/apb_slot_decode.sv ====
`timescale 1ns/1ps

// -------------------------------------
// APB slot decode, read data and
// response mux, error reply for slots
// with nothing behind them
// -------------------------------------

`include "periph_defs.svh"

module apb_slot_decode
    import periph_pkg::*;
(
    input  logic      psel_i,
    input  logic      penable_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t irq_rdata_i,
    input  apb_data_t timer_rdata_i,
    output logic      sel_irq_o,
    output logic      sel_timer_o,
    output reg_off_t  reg_off_o,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic [`SLOT_MSB-`SLOT_LSB:0] slot;
    logic                         slot_absent;

    assign slot      = paddr_i[`SLOT_MSB:`SLOT_LSB];
    assign reg_off_o = paddr_i[`REG_OFF_MSB:`REG_OFF_LSB];

    always_comb begin
        sel_irq_o   = 1'b0;
        sel_timer_o = 1'b0;
        slot_absent = 1'b0;
        prdata_o    = '0;
        case (slot)
            `SLOT_IRQ: begin
                sel_irq_o = psel_i;
                prdata_o  = irq_rdata_i;
            end
            `SLOT_TIMER: begin
                sel_timer_o = psel_i;
                prdata_o    = timer_rdata_i;
            end
            default: begin
                // SPI, Ethernet and all other slots stay unpopulated
                slot_absent = 1'b1;
                prdata_o    = `ABSENT_RDATA;
            end
        endcase
    end

    // No wait states
    assign pready_o  = psel_i;
    assign pslverr_o = psel_i & penable_i & slot_absent;

endmodule

// ==== logic/periph_pkg.sv ====
// -------------------------------------
// Vector types shared by the peripheral
// subsystem RTL
// -------------------------------------

`include "periph_defs.svh"

package periph_pkg;

    // APB address and data words
    typedef logic [`PERIPH_ADDR_W-1:0] apb_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] apb_data_t;

    // Word offset inside a slot
    typedef logic [`REG_OFF_MSB-`REG_OFF_LSB:0] reg_off_t;

    // One bit per interrupt source
    typedef logic [`NUM_IRQ_SRC-1:0] irq_vec_t;

    // Source number returned by a claim
    typedef logic [$clog2(`NUM_IRQ_SRC)-1:0] irq_id_t;

endpackage

// ==== include/periph_defs.svh ====
// -------------------------------------
// Bus widths, slot map, register offset
// fields and interrupt source numbers
// -------------------------------------

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32

// Slot select bits and slot numbers
`define SLOT_MSB   15
`define SLOT_LSB   12
`define SLOT_IRQ   4'd0
`define SLOT_TIMER 4'd1
`define SLOT_SPI   4'd2
`define SLOT_ETH   4'd3

// Word offset bits inside a slot
`define REG_OFF_MSB 4
`define REG_OFF_LSB 2

// Source 0 is reserved
`define NUM_IRQ_SRC    3
`define IRQ_SRC_TIMER0 1
`define IRQ_SRC_TIMER1 2

`define ABSENT_RDATA 32'hdeadbeef

`endif
